//--- all.f
+incdir+tb
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
tb/tb_rv_core.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_rv_core -f all.f \
	&& ./obj_dir/Vtb_rv_core \
	|| exit 1

//--- src/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
	input  rv_pkg::alu_op_e         op,
	input  logic [rv_pkg::XLEN-1:0] a,
	input  logic [rv_pkg::XLEN-1:0] b,
	output logic [rv_pkg::XLEN-1:0] result
);
	import rv_pkg::*;

	logic [4:0] shamt;	// Low five bits only
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b[4:0];
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			alu_add: begin
				result = a + b;
			end
			alu_sub: begin
				result = a - b;
			end
			alu_sll: begin
				result = a << shamt;
			end
			alu_srl: begin
				result = a >> shamt;	// Zero fill
			end
			alu_sra: begin
				result = $signed(a) >>> shamt;	// Sign fill
			end
			alu_slt: begin
				result = XLEN'(lt_signed);	// 0 or 1
			end
			alu_sltu: begin
				result = XLEN'(lt_unsigned);
			end
			alu_xor: begin
				result = a ^ b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_and: begin
				result = a & b;
			end
			default: begin
				result = '0;	// Unused encodings
			end
		endcase
	end

endmodule

//--- src/rv_core.sv
`timescale 1ns/100ps

module rv_core #(
	parameter int MEM_WORDS = 256
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instr_valid,
	input  logic [rv_pkg::XLEN-1:0] instr,
	output logic                    retire_valid,
	output rv_pkg::retire_t         retire
);
	import rv_pkg::*;

	ctrl_t                 ctrl;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic [XLEN-1:0]       op_b;
	logic [XLEN-1:0]       alu_result;
	logic [XLEN-1:0]       load_data;
	logic [XLEN-1:0]       wb_data;
	logic [XLEN-1:0]       word_addr;
	logic [XLEN-1:0]       new_word;
	logic [STRB_W-1:0]     strobe;
	logic [XLEN-1:0]       pc;
	logic                  rd_we;
	logic                  mem_we;

	rv_decoder rv_decoder_inst (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.ctrl(ctrl), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm)
	);

	rv_regfile rv_regfile_inst (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(rd_we), .rd(rd), .rd_data(wb_data)
	);

	assign op_b = ctrl.use_imm ? imm : rs2_data;

	rv_alu rv_alu_inst (.op(ctrl.alu_op), .a(rs1_data), .b(op_b), .result(alu_result));

	// LSU forms its own address beside the ALU
	rv_lsu #(.MEM_WORDS(MEM_WORDS)) rv_lsu_inst (
		.clk(clk), .en(instr_valid), .ctrl(ctrl),
		.base(rs1_data), .offset(imm), .store_data(rs2_data),
		.load_data(load_data), .word_addr(word_addr), .new_word(new_word), .strobe(strobe)
	);

	// Writeback mux and gated enables
	assign wb_data = ctrl.wb_from_mem ? load_data : alu_result;
	assign rd_we   = instr_valid && ctrl.reg_wr && rd != '0;
	assign mem_we  = instr_valid && ctrl.mem_wr;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc           <= '0;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= instr_valid;	// One cycle latency
			if (instr_valid) begin
				pc <= pc + XLEN'(4);
			end
		end
	end

	// Retire payload, captured with the accepted instruction
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			retire.pc         <= pc;	// PC before this instruction
			retire.rd_we      <= rd_we;
			retire.rd_addr    <= rd;
			retire.rd_data    <= wb_data;
			retire.mem_we     <= mem_we;
			retire.mem_addr   <= word_addr;
			retire.mem_wdata  <= new_word;
			retire.mem_strobe <= strobe;
		end
	end

endmodule

//--- src/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          instr_valid,
	input  logic [rv_pkg::XLEN-1:0]       instr,
	output rv_pkg::ctrl_t                 ctrl,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
	output logic [rv_pkg::REG_ADDR_W-1:0] rd,
	output logic [rv_pkg::XLEN-1:0]       imm
);
	import rv_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic       funct7_b5;	// Selects sub and sra

	// funct3 to ALU op, alt picks sub/sra
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_sel = alt ? alu_sub : alu_add;
			3'b001:  alu_sel = alu_sll;
			3'b010:  alu_sel = alu_slt;
			3'b011:  alu_sel = alu_sltu;
			3'b100:  alu_sel = alu_xor;
			3'b101:  alu_sel = alt ? alu_sra : alu_srl;
			3'b110:  alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	endfunction

	assign opcode    = opcode_e'(instr[6:0]);
	assign funct3    = instr[14:12];
	assign funct7_b5 = instr[30];

	// Register fields sit at fixed positions
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	always_comb begin
		ctrl        = '0;	// Unknown opcode falls through as nop
		ctrl.alu_op = alu_add;	// Address add for loads and stores
		ctrl.width  = mem_word;
		imm         = {{(XLEN-12){instr[31]}}, instr[31:20]};	// I-format
		case (opcode)
			op_reg: begin
				ctrl.reg_wr = 1'b1;
				ctrl.alu_op = alu_sel(funct3, funct7_b5);
			end
			op_imm: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op  = alu_sel(funct3, funct7_b5 && funct3 == 3'b101);	// No subi
			end
			op_load: begin
				ctrl.reg_wr      = 1'b1;
				ctrl.use_imm     = 1'b1;
				ctrl.mem_rd      = 1'b1;
				ctrl.wb_from_mem = 1'b1;
				ctrl.width       = mem_width_e'(funct3);
			end
			op_store: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_wr  = 1'b1;
				ctrl.width   = mem_width_e'(funct3);
				imm = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};	// S-format
			end
			default: ;
		endcase
	end

	// Only the four kept opcodes may be issued
	a_known_opcode: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> opcode inside {op_reg, op_imm, op_load, op_store})
		else $error("Unknown opcode %b", instr[6:0]);

endmodule

//--- src/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu #(
	parameter int MEM_WORDS = 256
) (
	input  logic                      clk,
	input  logic                      en,
	input  rv_pkg::ctrl_t             ctrl,
	input  logic [rv_pkg::XLEN-1:0]   base,
	input  logic [rv_pkg::XLEN-1:0]   offset,
	input  logic [rv_pkg::XLEN-1:0]   store_data,
	output logic [rv_pkg::XLEN-1:0]   load_data,
	output logic [rv_pkg::XLEN-1:0]   word_addr,
	output logic [rv_pkg::XLEN-1:0]   new_word,
	output logic [rv_pkg::STRB_W-1:0] strobe
);
	import rv_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [XLEN-1:0]   mem [MEM_WORDS];	// Data memory, no reset
	logic [XLEN-1:0]   addr;
	logic [1:0]        byte_off;
	logic [IDX_W-1:0]  idx;
	logic [XLEN-1:0]   old_word;
	logic [XLEN-1:0]   lane_data;	// Store data moved into its lane
	logic [STRB_W-1:0] lane_mask;
	logic [XLEN-1:0]   lane_shift;	// Load data moved down to bit 0
	logic              access;

	assign addr      = base + offset;	// Own address adder
	assign byte_off  = addr[1:0];
	assign idx       = addr[2 +: IDX_W];
	assign word_addr = {addr[XLEN-1:2], 2'b00};
	assign old_word  = mem[idx];
	assign access    = en && (ctrl.mem_rd || ctrl.mem_wr);

	// Store lane placement and byte mask
	always_comb begin
		lane_data = store_data;
		lane_mask = '1;
		case (ctrl.width)
			mem_byte: begin
				lane_data = XLEN'(store_data[7:0]) << {byte_off, 3'b000};
				lane_mask = STRB_W'(4'b0001) << byte_off;
			end
			mem_half: begin
				lane_data = XLEN'(store_data[15:0]) << {byte_off[1], 4'b0000};
				lane_mask = STRB_W'(4'b0011) << {byte_off[1], 1'b0};
			end
			default: ;	// Full word
		endcase
	end

	assign strobe = ctrl.mem_wr ? lane_mask : '0;	// Loads report no lanes

	// Merge enabled lanes over the current word
	always_comb begin
		for (int b = 0; b < STRB_W; b++) begin
			new_word[8*b +: 8] = strobe[b] ? lane_data[8*b +: 8] : old_word[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (en && ctrl.mem_wr) begin
			mem[idx] <= new_word;
		end
	end

	// Load lane select and extension
	assign lane_shift = old_word >> {byte_off, 3'b000};

	always_comb begin
		case (ctrl.width)
			mem_byte:   load_data = {{(XLEN-8){lane_shift[7]}}, lane_shift[7:0]};
			mem_half:   load_data = {{(XLEN-16){lane_shift[15]}}, lane_shift[15:0]};
			mem_byte_u: load_data = XLEN'(lane_shift[7:0]);
			mem_half_u: load_data = XLEN'(lane_shift[15:0]);
			default:    load_data = old_word;
		endcase
		if (!ctrl.mem_rd) begin
			load_data = '0;
		end
	end

	// Accesses stay inside the memory and naturally aligned
	a_addr_range: assert property (@(posedge clk)
		access |-> addr < XLEN'(MEM_WORDS * 4))
		else $error("Address %h out of range", addr);

	a_half_align: assert property (@(posedge clk)
		access && ctrl.width inside {mem_half, mem_half_u} |-> addr[0] == 1'b0)
		else $error("Misaligned half at %h", addr);

	a_word_align: assert property (@(posedge clk)
		access && ctrl.width == mem_word |-> byte_off == 2'b00)
		else $error("Misaligned word at %h", addr);

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

	// Datapath and address width
	localparam int XLEN = 32;
	// Register index width, 32 GPRs
	localparam int REG_ADDR_W = 5;
	// One strobe bit per byte lane
	localparam int STRB_W = XLEN / 8;

	// Major opcodes of the kept RV32I subset
	typedef enum logic [6:0] {
		op_reg   = 7'b0110011,	// R-type ALU
		op_imm   = 7'b0010011,	// I-type ALU
		op_load  = 7'b0000011,
		op_store = 7'b0100011
	} opcode_e;

	// ALU operation select
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sll  = 4'd1,
		alu_slt  = 4'd2,
		alu_sltu = 4'd3,
		alu_xor  = 4'd4,
		alu_srl  = 4'd5,
		alu_sra  = 4'd6,
		alu_or   = 4'd7,
		alu_and  = 4'd8,
		alu_sub  = 4'd9
	} alu_op_e;

	// Load/store funct3 encodings
	typedef enum logic [2:0] {
		mem_byte   = 3'b000,
		mem_half   = 3'b001,
		mem_word   = 3'b010,
		mem_byte_u = 3'b100,
		mem_half_u = 3'b101
	} mem_width_e;

	// Decoded control of one instruction
	typedef struct packed {
		logic       reg_wr;	// Writes rd
		logic       use_imm;	// Operand B from immediate
		logic       mem_rd;
		logic       mem_wr;
		logic       wb_from_mem;	// Writeback from load path
		alu_op_e    alu_op;
		mem_width_e width;
	} ctrl_t;

	// Retire report, one per accepted instruction
	typedef struct packed {
		logic [XLEN-1:0]       pc;	// PC before the instruction
		logic                  rd_we;
		logic [REG_ADDR_W-1:0] rd_addr;
		logic [XLEN-1:0]       rd_data;
		logic                  mem_we;
		logic [XLEN-1:0]       mem_addr;	// Word aligned
		logic [XLEN-1:0]       mem_wdata;	// Whole word after store
		logic [STRB_W-1:0]     mem_strobe;
	} retire_t;

endpackage

//--- src/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
	output logic [rv_pkg::XLEN-1:0]       rs1_data,
	output logic [rv_pkg::XLEN-1:0]       rs2_data,
	input  logic                          we,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
	input  logic [rv_pkg::XLEN-1:0]       rd_data
);
	import rv_pkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [XLEN-1:0] regs [NUM_REGS];

	// Single write port, x0 never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;	// All GPRs start at zero
			end
		end else if (we && rd != '0) begin
			regs[rd] <= rd_data;
		end
	end

	// Combinational read ports
	// Writes land at the edge, so the next instruction sees the new value
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];	// x0 reads zero since it stays cleared

	// x0 keeps its reset value for the whole run
	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		regs[0] == '0)
		else $error("x0 holds %h", regs[0]);

endmodule

//--- tb/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural state seen by the model
logic [31:0] m_regs [32];	// x0 never written
logic [31:0] m_mem [64];	// Test region, first 256 bytes
logic [31:0] m_pc = 32'd0;

function automatic logic [31:0] sext12(input logic [11:0] v);
	return {{20{v[11]}}, v};
endfunction

// RV32I integer ops by funct3, alt is funct7 bit 5
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'd0, $signed(a) < $signed(b)};
		3'd3: return {31'd0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// Applies one accepted instruction, returns the report it should retire
function automatic retire_t model_step(input logic [31:0] word);
	retire_t     e;
	logic [2:0]  f3;
	logic [4:0]  rd;
	logic [31:0] a;
	logic [31:0] addr;
	logic [31:0] old;
	logic [31:0] lane;
	logic [3:0]  strb;
	int          sh;
	f3        = word[14:12];
	rd        = word[11:7];
	a         = m_regs[word[19:15]];	// rs1
	e         = '0;
	e.pc      = m_pc;
	e.rd_addr = rd;
	case (word[6:0])
		7'b0110011: begin
			e.rd_we   = (rd != 5'd0);
			e.rd_data = alu_model(f3, word[30], a, m_regs[word[24:20]]);
		end
		7'b0010011: begin
			e.rd_we   = (rd != 5'd0);
			e.rd_data = alu_model(f3, word[30] && f3 == 3'd5, a, sext12(word[31:20]));	// No subi
		end
		7'b0000011: begin
			addr = a + sext12(word[31:20]);
			old  = m_mem[addr[7:2]];
			sh   = int'(addr[1:0]) * 8;
			lane = old >> sh;	// Addressed byte down to bit 0
			e.rd_we = (rd != 5'd0);
			case (f3)
				3'b000:  e.rd_data = {{24{lane[7]}}, lane[7:0]};
				3'b001:  e.rd_data = {{16{lane[15]}}, lane[15:0]};
				3'b100:  e.rd_data = {24'd0, lane[7:0]};
				3'b101:  e.rd_data = {16'd0, lane[15:0]};
				default: e.rd_data = old;
			endcase
		end
		7'b0100011: begin
			addr = a + sext12({word[31:25], word[11:7]});
			old  = m_mem[addr[7:2]];
			sh   = int'(addr[1:0]) * 8;
			lane = m_regs[word[24:20]] << sh;	// rs2 into its lane
			case (f3)
				3'b000:  strb = 4'b0001 << addr[1:0];
				3'b001:  strb = 4'b0011 << addr[1:0];
				default: strb = 4'b1111;
			endcase
			for (int b = 0; b < 4; b++) begin
				e.mem_wdata[8*b +: 8] = strb[b] ? lane[8*b +: 8] : old[8*b +: 8];
			end
			e.mem_we     = 1'b1;
			e.mem_addr   = {addr[31:2], 2'b00};
			e.mem_strobe = strb;
			m_mem[addr[7:2]] = e.mem_wdata;
		end
		default: ;
	endcase
	if (e.rd_we) begin
		m_regs[rd] = e.rd_data;
	end
	m_pc = m_pc + 32'd4;
	return e;
endfunction

`endif

//--- tb/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
	import rv_pkg::*;

	localparam int NUM_RANDOM  = 2000;
	localparam int FILL_WORDS  = 64;	// Loads and stores stay below 256 bytes
	localparam int TOTAL_INSTR = 31 + FILL_WORDS + NUM_RANDOM;
	localparam int MAX_CYCLES  = TOTAL_INSTR * 2 + 100;	// Idle one in eight plus margin

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic        retire_valid;
	retire_t     retire;

	logic [31:0] seed = 32'hb58c_e9e2;
	retire_t     exp_q [$];	// Expected reports in issue order
	logic        prev_valid = 1'b0;	// Instruction accepted at last edge
	string       test_name = "reset";
	int          cycle_count = 0;

	`include "rv_ref_model.svh"

	rv_core #(.MEM_WORDS(256)) rv_core_inst (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.retire_valid(retire_valid), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Simulation failed");
			$fatal(1, "Timeout, run still going after %0d cycles", MAX_CYCLES);
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		return int'((next_rand() >> 16) % 32'(n));	// High bits since low ones cycle fast
	endfunction

	// Legal instruction of the supported subset
	function automatic logic [31:0] gen_random_instr();
		logic [31:0] r;
		logic [31:0] r2;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [7:0]  addr;
		int          kind;
		r    = next_rand();
		r2   = next_rand();
		kind = int'(r[31:28]);
		f3   = r[27:25];
		imm  = r2[31:20];
		addr = r2[15:8];
		if (kind < 6) begin	// Register ALU
			return {1'b0, (f3 == 3'd0 || f3 == 3'd5) && r[9], 5'd0, r[14:10], r[19:15], f3,
				r[24:20], 7'b0110011};
		end else if (kind < 11) begin	// Immediate ALU
			if (f3 == 3'd1) begin
				imm[11:5] = 7'd0;
			end else if (f3 == 3'd5) begin
				imm[11:5] = {1'b0, r[9], 5'd0};	// srai or srli
			end
			return {imm, r[19:15], f3, r[24:20], 7'b0010011};
		end else if (kind < 13) begin	// Load from base x0
			case (rand_below(5))
				0:       f3 = 3'b000;
				1:       f3 = 3'b001;
				2:       f3 = 3'b010;
				3:       f3 = 3'b100;
				default: f3 = 3'b101;
			endcase
			if (f3[0]) addr[0] = 1'b0;	// Half aligned
			if (f3 == 3'b010) addr[1:0] = 2'b00;
			return {4'd0, addr, 5'd0, f3, r[24:20], 7'b0000011};
		end
		f3 = 3'(rand_below(3));	// Store sb, sh, sw
		if (f3 == 3'd1) addr[0] = 1'b0;
		if (f3 == 3'd2) addr[1:0] = 2'b00;
		return {4'd0, addr[7:5], r[14:10], 5'd0, f3, addr[4:0], 7'b0100011};
	endfunction

	task automatic fail_value(input string field, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Fail %s %s expected %h actual %h", test_name, field, exp, act);
		$display("Simulation failed");
		$fatal(1, "Stopped at first mismatch");
	endtask

	// Report of the instruction accepted at the last rising edge
	task automatic check_retire();
		retire_t e;
		assert (retire_valid == prev_valid)
			else fail_value("retire_valid", 32'(prev_valid), 32'(retire_valid));
		if (prev_valid) begin
			e = exp_q.pop_front();
			assert (retire.pc == e.pc) else fail_value("pc", e.pc, retire.pc);
			assert (retire.rd_we == e.rd_we)
				else fail_value("rd_we", 32'(e.rd_we), 32'(retire.rd_we));
			assert (retire.rd_addr == e.rd_addr)
				else fail_value("rd_addr", 32'(e.rd_addr), 32'(retire.rd_addr));
			assert (retire.mem_we == e.mem_we)
				else fail_value("mem_we", 32'(e.mem_we), 32'(retire.mem_we));
			if (e.rd_we) begin	// Data only meaningful with a write
				assert (retire.rd_data == e.rd_data)
					else fail_value("rd_data", e.rd_data, retire.rd_data);
			end
			if (e.mem_we) begin
				assert (retire.mem_addr == e.mem_addr)
					else fail_value("mem_addr", e.mem_addr, retire.mem_addr);
				assert (retire.mem_wdata == e.mem_wdata)
					else fail_value("mem_wdata", e.mem_wdata, retire.mem_wdata);
				assert (retire.mem_strobe == e.mem_strobe)
					else fail_value("mem_strobe", 32'(e.mem_strobe), 32'(retire.mem_strobe));
			end
		end
	endtask

	// Check the last report and drive the next input on a falling edge
	task automatic drive_cycle(input logic valid, input logic [31:0] word);
		@(negedge clk);
		check_retire();
		instr_valid = valid;
		instr       = word;
		if (valid) begin
			exp_q.push_back(model_step(word));
		end
		prev_valid = valid;
	endtask

	task automatic issue(input logic [31:0] word);
		if (rand_below(8) == 0) begin
			drive_cycle(1'b0, gen_random_instr());	// Idle cycle must leave no trace
		end
		drive_cycle(1'b1, word);
	endtask

	initial begin
		logic [11:0] imm;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = 32'd0;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = 32'd0;
		end
		repeat (4) begin
			@(negedge clk);
			assert (retire_valid == 1'b0)
				else fail_value("retire_valid", 32'd0, 32'(retire_valid));
		end
		reset = 1'b0;

		test_name = "warmup";	// Each addi reads its own rd straight after reset
		for (int i = 1; i < 32; i++) begin
			imm = 12'(next_rand() >> 20);
			issue({imm, 5'(i), 3'b000, 5'(i), 7'b0010011});
		end

		test_name = "fill";	// sw over the test region before any load
		for (int w = 0; w < FILL_WORDS; w++) begin
			imm = 12'(w * 4);
			issue({imm[11:5], 5'(rand_below(32)), 5'd0, 3'b010, imm[4:0], 7'b0100011});
		end

		test_name = "random";
		for (int n = 0; n < NUM_RANDOM; n++) begin
			issue(gen_random_instr());
		end

		test_name = "drain";
		drive_cycle(1'b0, 32'd0);	// Collect the last report
		drive_cycle(1'b0, 32'd0);
		$display("Simulation passed");
		$finish;
	end

endmodule
